// File: Makefile
TOOL       = verilator
TOP        = stream_matcher_tb
FILELIST   = filelist.f
BUILD_DIR  = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
logic/stream_pkg.sv
logic/match_pkg.sv
logic/ctx_if.sv
logic/stream_decode.sv
logic/keyword_dfa.sv
logic/match_tally.sv
logic/stream_matcher_top.sv
tb/stream_matcher_assert.sv
tb/stream_matcher_tb.sv

// File: logic/ctx_if.sv
interface ctx_if;
   import match_pkg::*;

   // One-cycle pulse that loads restore_state into the DFA
   logic       restore;
   // State to load on restore
   dfa_state_e restore_state;
   // Current DFA state as seen by the context memory
   dfa_state_e live_state;
   // Enabled end of packet where live_state is written back
   logic       save;

   // Decode side owns packet control and the context memory
   modport decode (
      output restore,
      output restore_state,
      output save,
      input  live_state
   );

   // Execute side owns the DFA state register
   modport execute (
      input  restore,
      input  restore_state,
      output live_state
   );

endinterface

// File: logic/keyword_dfa.sv
module keyword_dfa (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       char_vld,
   input  logic [7:0] char_in,
   ctx_if.execute     ctx,
   output logic       accept
);
   import match_pkg::*;

   dfa_state_e state_q;
   dfa_state_e state_d;
   // Byte completes the keyword this cycle
   logic       hit;

   // Next state for the current byte
   always_comb
   begin
      state_d = state_q;
      hit     = 1'b0;
      if (char_vld)
      begin
         // Default on mismatch
         // An 'S' may still start a new keyword
         state_d = (char_in == KW_C0) ? ST_S : ST_IDLE;
         case (state_q)
            ST_S:
            begin
               if (char_in == KW_C1)
                  state_d = ST_SI;
            end
            ST_SI:
            begin
               if (char_in == KW_C2)
                  state_d = ST_SIT;
            end
            ST_SIT:
            begin
               if (char_in == KW_C3)
               begin
                  hit     = 1'b1;
                  state_d = ST_IDLE;
               end
            end
            default:
            begin
               // ST_IDLE handled by the default above
            end
         endcase
      end
   end

   // State register with context restore
   // Restore wins over a byte in the same cycle
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= ST_IDLE;
         accept  <= 1'b0;
      end
      else if (ctx.restore)
      begin
         state_q <= ctx.restore_state;
         accept  <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         accept  <= hit;
      end
   end

   // Exported for the context save at end of packet
   assign ctx.live_state = state_q;

endmodule

// File: logic/match_pkg.sv
package match_pkg;

   // DFA states for the keyword
   // Each state names the prefix matched so far
   // Encoding is also the saved per-stream context
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_S    = 2'd1,
      ST_SI   = 2'd2,
      ST_SIT  = 2'd3
   } dfa_state_e;

   // Keyword bytes in scan order
   localparam logic [7:0] KW_C0 = "S";
   localparam logic [7:0] KW_C1 = "I";
   localparam logic [7:0] KW_C2 = "T";
   // Final byte completes the match
   localparam logic [7:0] KW_C3 = "E";

   // Global match counter width
   // Counter wraps silently at the top
   localparam int COUNT_W = 16;

endpackage

// File: logic/match_tally.sv
module match_tally (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         accept,
   input  logic                         pkt_clear,
   input  logic                         pkt_commit,
   input  logic                         pkt_drop,
   output logic                         fired,
   output logic [match_pkg::COUNT_W-1:0] count
);
   import match_pkg::*;

   // Sticky flag for the packet in flight
   // Counter sums flags of enabled packets only
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         fired <= 1'b0;
         count <= '0;
      end
      else
      begin
         // New packet starts clean
         if (pkt_clear)
            fired <= 1'b0;

         // A hit overrides the start-of-packet clear
         if (accept)
            fired <= 1'b1;

         // Disabled packet discards its flag uncounted
         if (pkt_drop)
            fired <= 1'b0;

         // At most one count per packet however many hits
         if (pkt_commit)
            count <= count + COUNT_W'(fired);
      end
   end

endmodule

// File: logic/stream_decode.sv
module stream_decode (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   load_state,
   input  logic                   new_stream_id,
   input  logic                   eop,
   input  logic                   enable,
   input  stream_pkg::stream_id_t stream_id,
   ctx_if.decode                  ctx,
   output logic                   pkt_clear,
   output logic                   pkt_commit,
   output logic                   pkt_drop
);
   import stream_pkg::*;
   import match_pkg::*;

   // Saved DFA state per stream
   // Written only at an enabled end of packet
   dfa_state_e ctx_mem [NUM_STREAMS];

   // Tally strobes follow the packet boundary pulses directly
   assign pkt_clear  = load_state;
   assign pkt_commit = eop & enable;
   assign pkt_drop   = eop & ~enable;

   // Same condition also stores the DFA state
   assign ctx.save = eop & enable;

   // Restore pulse lands one cycle after load_state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         ctx.restore <= 1'b0;
      end
      else
      begin
         ctx.restore <= load_state;
      end
   end

   // Restore value is picked on the load_state edge
   // A new stream starts from scratch
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         if (new_stream_id)
         begin
            ctx.restore_state <= ST_IDLE;
         end
         else
         begin
            // Resume where the last enabled packet left off
            ctx.restore_state <= ctx_mem[stream_id];
         end
      end
   end

   // Write back live DFA state so a keyword split
   // across packets of one stream is still found
   always_ff @(posedge clk)
   begin
      if (ctx.save)
      begin
         ctx_mem[stream_id] <= ctx.live_state;
      end
   end

endmodule

// File: logic/stream_matcher_top.sv
module stream_matcher_top (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [7:0]                   char_in,
   input  logic                         char_in_vld,
   input  logic                         load_state,
   input  logic                         new_stream_id,
   input  stream_pkg::stream_id_t       stream_id,
   input  logic                         eop,
   input  logic                         enable,
   output logic [match_pkg::COUNT_W-1:0] count,
   output logic                         fired
);

   // Tally strobes from decode
   logic pkt_clear;
   logic pkt_commit;
   logic pkt_drop;
   // Registered hit from the DFA
   logic accept;

   // Restore and save path between decode and execute
   ctx_if u_ctx_if ();

   // Packet control and per-stream context
   stream_decode u_stream_decode (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .eop           (eop),
      .enable        (enable),
      .stream_id     (stream_id),
      .ctx           (u_ctx_if.decode),
      .pkt_clear     (pkt_clear),
      .pkt_commit    (pkt_commit),
      .pkt_drop      (pkt_drop)
   );

   // Keyword scan
   keyword_dfa u_keyword_dfa (
      .clk      (clk),
      .rst_n    (rst_n),
      .char_vld (char_in_vld),
      .char_in  (char_in),
      .ctx      (u_ctx_if.execute),
      .accept   (accept)
   );

   // Match flag and global counter
   match_tally u_match_tally (
      .clk        (clk),
      .rst_n      (rst_n),
      .accept     (accept),
      .pkt_clear  (pkt_clear),
      .pkt_commit (pkt_commit),
      .pkt_drop   (pkt_drop),
      .fired      (fired),
      .count      (count)
   );

endmodule

// File: logic/stream_pkg.sv
package stream_pkg;

   // Stream id width
   // Six bits cover up to 64 interleaved streams
   localparam int STREAM_ID_W = 6;

   // One context slot per possible stream id
   localparam int NUM_STREAMS = 1 << STREAM_ID_W;

   // Stream id as seen on the packet control inputs
   // Held for the whole packet by the source
   typedef logic [STREAM_ID_W-1:0] stream_id_t;

endpackage

// File: tb/stream_matcher_assert.sv
module stream_matcher_assert (
   input logic                          clk,
   input logic                          rst_n,
   input logic                          load_state,
   input logic                          eop,
   input logic                          pkt_clear,
   input logic                          accept,
   input logic                          fired,
   input logic [match_pkg::COUNT_W-1:0] count,
   input logic                          restore
);
   timeunit 1ns;
   timeprecision 1ps;

   // Packet start with no hit leaves the flag low
   a_fired_clear : assert property (@(posedge clk) disable iff (!rst_n)
      pkt_clear && !accept |=> !fired)
      else $error("fired set after packet start without accept");

   // Counter moves only on an end of packet edge
   a_count_stable : assert property (@(posedge clk) disable iff (!rst_n)
      !eop |=> $stable(count))
      else $error("count changed without eop");

   // Restore pulse trails load_state by exactly one cycle
   a_restore_follow : assert property (@(posedge clk) disable iff (!rst_n)
      load_state |=> restore)
      else $error("restore missing after load_state");
   a_restore_only : assert property (@(posedge clk) disable iff (!rst_n)
      !load_state |=> !restore)
      else $error("restore without preceding load_state");

endmodule

bind stream_matcher_top stream_matcher_assert u_stream_matcher_assert (
   .clk        (clk),
   .rst_n      (rst_n),
   .load_state (load_state),
   .eop        (eop),
   .pkt_clear  (pkt_clear),
   .accept     (accept),
   .fired      (fired),
   .count      (count),
   .restore    (u_ctx_if.restore)
);

// File: tb/stream_matcher_tb.sv
module stream_matcher_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import stream_pkg::*;
   import match_pkg::*;

   // Longest packet takes 16 cycles, about 200 packets with margin
   localparam int MAX_CYCLES = 4000;
   localparam int RAND_PACKETS = 160;

   logic                   clk;
   logic                   rst_n;
   logic [7:0]             char_in;
   logic                   char_in_vld;
   logic                   load_state;
   logic                   new_stream_id;
   logic [STREAM_ID_W-1:0] stream_id;
   logic                   eop;
   logic                   enable;
   logic [COUNT_W-1:0]     count;
   logic                   fired;

   // Reference model state
   logic [1:0]             ref_mem [NUM_STREAMS];
   bit                     seen [NUM_STREAMS];
   logic [COUNT_W-1:0]     ref_count;
   logic [7:0]             pkt_bytes [$];
   string                  kw = "SITE";

   // Strobes and expected values handed to the compare process
   logic                   chk_count;
   logic                   chk_fired;
   logic [COUNT_W-1:0]     exp_count;
   logic                   exp_fired;

   int                     err_count;
   int                     err_fired;
   int                     cycle_cnt;
   integer                 seed;

   stream_matcher_top u_stream_matcher_top (
      .clk           (clk),
      .rst_n         (rst_n),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .stream_id     (stream_id),
      .eop           (eop),
      .enable        (enable),
      .count         (count),
      .fired         (fired)
   );

   always #5 clk = ~clk;

   // Keyword scan rule
   // Bit 2 flags a completed keyword, low bits hold the next state
   function automatic logic [2:0] dfa_next(input logic [1:0] st, input logic [7:0] b);
      logic [7:0] want;
      want = kw[st];
      if (b == want)
      begin
         if (st == 2'd3)
            return 3'b100;
         return {1'b0, st + 2'd1};
      end
      // Mismatch, but an S still opens a new keyword
      if (b == "S")
         return 3'b001;
      return 3'b000;
   endfunction

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // Advance one cycle and drop all one-cycle strobes
   task automatic next_cycle();
      @(posedge clk);
      #1;
      load_state  = 1'b0;
      eop         = 1'b0;
      char_in_vld = 1'b0;
      chk_count   = 1'b0;
      chk_fired   = 1'b0;
   endtask

   task automatic load_text(input string s);
      pkt_bytes.delete();
      for (int i = 0; i < s.len(); i++)
         pkt_bytes.push_back(s[i]);
   endtask

   // One packet of pkt_bytes, run through the DUT and the model side by side
   task automatic send_packet(input logic [STREAM_ID_W-1:0] sid, input bit is_new,
                              input bit en);
      logic [1:0] st;
      logic       hit;
      bit         pkt_flag;
      next_cycle();
      load_state    = 1'b1;
      new_stream_id = is_new;
      stream_id     = sid;
      st            = is_new ? 2'd0 : ref_mem[sid];
      pkt_flag      = 1'b0;
      // Restore still in flight, no byte here
      next_cycle();
      foreach (pkt_bytes[i])
      begin
         next_cycle();
         char_in_vld = 1'b1;
         char_in     = pkt_bytes[i];
         {hit, st}   = dfa_next(st, pkt_bytes[i]);
         if (hit)
            pkt_flag = 1'b1;
      end
      // Accept of a final byte lands here
      next_cycle();
      next_cycle();
      chk_fired = 1'b1;
      exp_fired = pkt_flag;
      next_cycle();
      eop    = 1'b1;
      enable = en;
      if (en)
      begin
         ref_count    = ref_count + COUNT_W'(pkt_flag);
         ref_mem[sid] = st;
         seen[sid]    = 1'b1;
      end
      // Counter settled, a dropped packet leaves the flag clear
      next_cycle();
      chk_count = 1'b1;
      exp_count = ref_count;
      chk_fired = 1'b1;
      exp_fired = en ? pkt_flag : 1'b0;
   endtask

   task automatic random_packet();
      logic [STREAM_ID_W-1:0] sid;
      bit                     is_new;
      int                     len;
      sid = STREAM_ID_W'(8 + rand_below(8));
      // Stream without a saved context must be marked new
      is_new = !seen[sid] || (rand_below(8) == 0);
      len = rand_below(11);
      pkt_bytes.delete();
      for (int i = 0; i < len; i++)
      begin
         // Lean toward keyword letters so hits and splits happen often
         if (rand_below(8) < 6)
            pkt_bytes.push_back(kw[rand_below(4)]);
         else
            pkt_bytes.push_back(8'(rand_below(256)));
      end
      send_packet(sid, is_new, rand_below(4) != 0);
   endtask

   // Compare process, outputs sampled mid-cycle where they are stable
   always @(negedge clk)
   begin
      if (chk_count)
      begin
         assert (count === exp_count)
         else
         begin
            err_count++;
            $display("ERR count got 0x%04h expected 0x%04h at %0t", count, exp_count, $time);
         end
      end
      if (chk_fired)
      begin
         assert (fired === exp_fired)
         else
         begin
            err_fired++;
            $display("ERR fired got 0x%0h expected 0x%0h at %0t", fired, exp_fired, $time);
         end
      end
   end

   // Run limit
   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("Timeout after %0d cycles, stimulus never completed", cycle_cnt);
         $display("Testbench failed");
         $finish;
      end
   end

   initial
   begin
      clk           = 1'b0;
      rst_n         = 1'b0;
      char_in       = 8'h00;
      char_in_vld   = 1'b0;
      load_state    = 1'b0;
      new_stream_id = 1'b0;
      stream_id     = '0;
      eop           = 1'b0;
      enable        = 1'b0;
      chk_count     = 1'b0;
      chk_fired     = 1'b0;
      exp_count     = '0;
      exp_fired     = 1'b0;
      ref_count     = '0;
      err_count     = 0;
      err_fired     = 0;
      cycle_cnt     = 0;
      seed          = 64494;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Idle state after reset
      next_cycle();
      chk_count = 1'b1;
      chk_fired = 1'b1;

      // Single hit, then two hits counted once
      load_text("XXSITEYY");
      send_packet(6'd1, 1'b1, 1'b1);
      load_text("SITESITE");
      send_packet(6'd2, 1'b1, 1'b1);

      // Split keyword resumes, but not across a new stream mark
      load_text("ABSI");
      send_packet(6'd3, 1'b1, 1'b1);
      load_text("TEQ");
      send_packet(6'd3, 1'b0, 1'b1);
      load_text("QSIT");
      send_packet(6'd4, 1'b1, 1'b1);
      load_text("EZ");
      send_packet(6'd4, 1'b1, 1'b1);

      // Interleaved streams keep separate partial matches
      load_text("ZSI");
      send_packet(6'd5, 1'b1, 1'b1);
      load_text("TEZ");
      send_packet(6'd6, 1'b1, 1'b1);
      load_text("TE");
      send_packet(6'd5, 1'b0, 1'b1);

      // Disabled packet neither counts nor saves its state
      load_text("SI");
      send_packet(6'd7, 1'b1, 1'b1);
      load_text("TESIT");
      send_packet(6'd7, 1'b0, 1'b0);
      load_text("TE");
      send_packet(6'd7, 1'b0, 1'b1);

      repeat (RAND_PACKETS) random_packet();
      next_cycle();

      $display("Errors: %0d on count, %0d on fired", err_count, err_fired);
      if (err_count + err_fired == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule
